// ==== common/wb_cfg.svh ====
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// ----------------------------------------------------------
// Program layout
// ----------------------------------------------------------

// Address of the last instruction of a program.
`define WB_EXIT_PC 32'hffff_ff00

// Initial stack pointer, loaded into x2 on reset.
`define WB_SP_RESET 32'h0000_7500

// ----------------------------------------------------------
// Register file
// ----------------------------------------------------------

`define WB_REG_COUNT 32

`endif

// ==== common/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // ----------------------------------------------------------
    // Writeback result select
    // ----------------------------------------------------------

    typedef logic [2:0] wb_sel_t;

    localparam wb_sel_t WB_ALU   = 3'd0;  // ALU result, also the fallback.
    localparam wb_sel_t WB_MEMB  = 3'd1;  // Signed byte load.
    localparam wb_sel_t WB_MEMBU = 3'd2;  // Unsigned byte load.
    localparam wb_sel_t WB_MEMH  = 3'd3;  // Signed halfword load.
    localparam wb_sel_t WB_MEMHU = 3'd4;  // Unsigned halfword load.
    localparam wb_sel_t WB_MEMW  = 3'd5;  // Full word load.
    localparam wb_sel_t WB_PC    = 3'd6;  // Link address for jal and jalr.
    localparam wb_sel_t WB_CSR   = 3'd7;  // CSR read value.

    // ----------------------------------------------------------
    // Instruction ids
    // ----------------------------------------------------------

    // The decoder never hands out an id with the top 16 bits set, so this
    // value can never match a real instruction and the first valid
    // instruction after reset always counts as new.
    localparam logic [63:0] INST_ID_NONE = 64'hffff_0000_0000_0000;

endpackage

`default_nettype wire

// ==== writeback/wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "wb_cfg.svh"

module wb_stage (
    input  wire                   clk,
    input  wire                   arst_n_i,

    // Instruction leaving the memory stage.
    input  wire                   wb_valid_i,
    input  wire  [31:0]           wb_pc_i,
    input  wire  [63:0]           wb_inst_id_i,
    input  wire  wb_pkg::wb_sel_t wb_sel_i,
    input  wire                   rf_wen_i,
    input  wire  [4:0]            rd_addr_i,
    input  wire  [31:0]           alu_out_i,
    input  wire  [31:0]           mem_rdata_i,
    input  wire  [31:0]           csr_rdata_i,

    // Result, also used for forwarding.
    output logic [31:0]           wb_data_o,

    // Register file write port.
    output logic                  rf_we_o,
    output logic [4:0]            rf_waddr_o,

    output logic [31:0]           retire_count_o,
    output logic                  exit_o
);

    import wb_pkg::*;

    // ----------------------------------------------------------
    // Result selection
    // ----------------------------------------------------------

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic [31:0] pc_plus4;

    assign load_byte = mem_rdata_i[7:0];
    assign load_half = mem_rdata_i[15:0];
    assign pc_plus4  = wb_pc_i + 32'd4;  // Return address of a jump.

    always_comb begin
        case (wb_sel_i)
            WB_ALU:   wb_data_o = alu_out_i;
            WB_MEMB:  wb_data_o = {{24{load_byte[7]}}, load_byte};
            WB_MEMBU: wb_data_o = {24'd0, load_byte};
            WB_MEMH:  wb_data_o = {{16{load_half[15]}}, load_half};
            WB_MEMHU: wb_data_o = {16'd0, load_half};
            WB_MEMW:  wb_data_o = mem_rdata_i;
            WB_PC:    wb_data_o = pc_plus4;
            WB_CSR:   wb_data_o = csr_rdata_i;
            default:  wb_data_o = alu_out_i;  // Only reached on an X select.
        endcase
    end

    // ----------------------------------------------------------
    // Retirement detection
    // ----------------------------------------------------------

    // While the pipeline stalls, the same instruction sits in writeback for
    // several cycles. Only the first cycle with a given id retires it.
    logic [63:0] saved_inst_id;
    logic        is_new_inst;

    assign is_new_inst = wb_valid_i && (wb_inst_id_i != saved_inst_id);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            saved_inst_id <= INST_ID_NONE;
        end else if (wb_valid_i) begin
            saved_inst_id <= wb_inst_id_i;
        end
    end

    // The write goes in on the edge that ends the retiring cycle.
    assign rf_we_o    = is_new_inst && rf_wen_i;
    assign rf_waddr_o = rd_addr_i;

    // ----------------------------------------------------------
    // Retire counter and exit flag
    // ----------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_count_o <= 32'd0;
        end else if (is_new_inst) begin
            retire_count_o <= retire_count_o + 32'd1;
        end
    end

    // Program end is reached once the final instruction is in writeback.
    assign exit_o = wb_valid_i && (wb_pc_i == `WB_EXIT_PC);

endmodule

`default_nettype wire

// ==== writeback/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "wb_cfg.svh"

module reg_file (
    input  wire         clk,
    input  wire         arst_n_i,

    // Write port, driven from writeback.
    input  wire         we_i,
    input  wire  [4:0]  waddr_i,
    input  wire  [31:0] wdata_i,

    // Two combinational read ports for decode.
    input  wire  [4:0]  raddr_a_i,
    input  wire  [4:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    localparam logic [4:0] SP_ADDR = 5'd2;

    logic [31:0] regs [`WB_REG_COUNT];

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------

    // Everything resets to all ones so that a read of an unwritten register
    // stands out, except the stack pointer, which a program needs from its
    // first instruction.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `WB_REG_COUNT; i++) begin
                regs[i] <= 32'hffff_ffff;
            end
            regs[SP_ADDR] <= `WB_SP_RESET;
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;  // x0 is never written.
        end
    end

    // ----------------------------------------------------------
    // Read ports
    // ----------------------------------------------------------

    // x0 is hardwired to zero. Its storage entry is never looked at.
    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== verilog/wb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_top (
    input  wire                   clk,
    input  wire                   arst_n_i,

    // From the memory stage.
    input  wire                   wb_valid_i,
    input  wire  [31:0]           wb_pc_i,
    input  wire  [63:0]           wb_inst_id_i,
    input  wire  wb_pkg::wb_sel_t wb_sel_i,
    input  wire                   rf_wen_i,
    input  wire  [4:0]            rd_addr_i,
    input  wire  [31:0]           alu_out_i,
    input  wire  [31:0]           mem_rdata_i,
    input  wire  [31:0]           csr_rdata_i,

    // Register reads for the decode stage.
    input  wire  [4:0]            rs1_addr_i,
    input  wire  [4:0]            rs2_addr_i,
    output logic [31:0]           rs1_data_o,
    output logic [31:0]           rs2_data_o,

    output logic [31:0]           wb_data_o,
    output logic [31:0]           retire_count_o,
    output logic                  exit_o
);

    // ----------------------------------------------------------
    // Writeback to register file
    // ----------------------------------------------------------

    logic       rf_we;
    logic [4:0] rf_waddr;

    wb_stage u_wb_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .wb_valid_i     (wb_valid_i),
        .wb_pc_i        (wb_pc_i),
        .wb_inst_id_i   (wb_inst_id_i),
        .wb_sel_i       (wb_sel_i),
        .rf_wen_i       (rf_wen_i),
        .rd_addr_i      (rd_addr_i),
        .alu_out_i      (alu_out_i),
        .mem_rdata_i    (mem_rdata_i),
        .csr_rdata_i    (csr_rdata_i),
        .wb_data_o      (wb_data_o),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .retire_count_o (retire_count_o),
        .exit_o         (exit_o)
    );

    // The forwarded result is also the write data.
    reg_file u_reg_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (wb_data_o),
        .raddr_a_i  (rs1_addr_i),
        .raddr_b_i  (rs2_addr_i),
        .rdata_a_o  (rs1_data_o),
        .rdata_b_o  (rs2_data_o)
    );

endmodule

`default_nettype wire

// ==== test/wb_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_properties (
    input wire        clk,
    input wire        arst_n_i,
    input wire        wb_valid_i,
    input wire [63:0] wb_inst_id_i,
    input wire        rf_we_i,
    input wire [31:0] retire_count_i
);

    // A register write always belongs to an instruction that is really there.
    no_write_without_valid: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !wb_valid_i |-> !rf_we_i
    ) else $error("register write enable high with no valid instruction");

    // Two valid cycles in a row with one id are a stall, not a retirement.
    count_held_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (wb_valid_i && $past(wb_valid_i) && (wb_inst_id_i == $past(wb_inst_id_i)))
            |=> $stable(retire_count_i)
    ) else $error("retire count changed while the instruction id was held");

endmodule

bind wb_stage wb_properties u_properties (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .wb_valid_i     (wb_valid_i),
    .wb_inst_id_i   (wb_inst_id_i),
    .rf_we_i        (rf_we_o),
    .retire_count_i (retire_count_o)
);

`default_nettype wire

// ==== test/wb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "wb_cfg.svh"

module wb_checker (
    input  wire                   clk,
    input  wire                   arst_n_i,

    // Inputs of the DUT.
    input  wire                   wb_valid_i,
    input  wire  [31:0]           wb_pc_i,
    input  wire  [63:0]           wb_inst_id_i,
    input  wire  wb_pkg::wb_sel_t wb_sel_i,
    input  wire                   rf_wen_i,
    input  wire  [4:0]            rd_addr_i,
    input  wire  [31:0]           alu_out_i,
    input  wire  [31:0]           mem_rdata_i,
    input  wire  [31:0]           csr_rdata_i,
    input  wire  [4:0]            rs1_addr_i,
    input  wire  [4:0]            rs2_addr_i,

    // Outputs of the DUT.
    input  wire  [31:0]           rs1_data_i,
    input  wire  [31:0]           rs2_data_i,
    input  wire  [31:0]           wb_data_i,
    input  wire  [31:0]           retire_count_i,
    input  wire                   exit_i,

    output int                    error_count_o,
    output int                    check_count_o
);

    import wb_pkg::*;

    logic [31:0] model_regs [`WB_REG_COUNT];
    logic [63:0] model_last_id;
    logic [31:0] model_retired;
    int          mismatches = 0;
    int          checks = 0;

    assign error_count_o = mismatches;
    assign check_count_o = checks;

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    function automatic logic [31:0] expected_result(input wb_sel_t     sel,
                                                    input logic [31:0] pc,
                                                    input logic [31:0] alu,
                                                    input logic [31:0] mem,
                                                    input logic [31:0] csr);
        case (sel)
            WB_MEMB:  return mem[7] ? (mem | 32'hffff_ff00) : (mem & 32'h0000_00ff);
            WB_MEMBU: return mem & 32'h0000_00ff;
            WB_MEMH:  return mem[15] ? (mem | 32'hffff_0000) : (mem & 32'h0000_ffff);
            WB_MEMHU: return mem & 32'h0000_ffff;
            WB_MEMW:  return mem;
            WB_PC:    return pc + 32'd4;  // Link address.
            WB_CSR:   return csr;
            default:  return alu;
        endcase
    endfunction

    task automatic reset_model();
        for (int i = 0; i < `WB_REG_COUNT; i++) begin
            model_regs[i] = 32'hffff_ffff;
        end
        model_regs[0] = 32'd0;  // x0 always reads as zero.
        model_regs[2] = `WB_SP_RESET;
        model_last_id = INST_ID_NONE;
        model_retired = 32'd0;
    endtask

    task automatic check_value(input string       name,
                               input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // ----------------------------------------------------------
    // Comparison
    // ----------------------------------------------------------

    // Inputs change on the rising edge, so the falling edge sees a settled cycle.
    always @(negedge clk) begin : compare
        logic [31:0] exp_data;
        logic        exp_exit;

        if (!arst_n_i) begin
            reset_model();
        end else begin
            exp_data = expected_result(wb_sel_i, wb_pc_i, alu_out_i, mem_rdata_i, csr_rdata_i);
            exp_exit = wb_valid_i && (wb_pc_i == `WB_EXIT_PC);

            check_value("rs1_data_o", rs1_data_i, model_regs[rs1_addr_i]);
            check_value("rs2_data_o", rs2_data_i, model_regs[rs2_addr_i]);
            check_value("wb_data_o", wb_data_i, exp_data);
            check_value("retire_count_o", retire_count_i, model_retired);
            check_value("exit_o", {31'd0, exit_i}, {31'd0, exp_exit});

            // Only a valid id that differs from the last one retires.
            if (wb_valid_i && (wb_inst_id_i != model_last_id)) begin
                model_retired = model_retired + 32'd1;
                model_last_id = wb_inst_id_i;
                if (rf_wen_i && (rd_addr_i != 5'd0)) begin
                    model_regs[rd_addr_i] = exp_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/wb_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "wb_cfg.svh"

module wb_tb;

    import wb_pkg::*;

    localparam int WAIT_LIMIT  = 16;    // Cycles any single wait may take.
    localparam int CYCLE_LIMIT = 5000;  // Hard stop for the whole run.

    logic        clk;
    logic        arst_n_i;
    logic        wb_valid_i;
    logic [31:0] wb_pc_i;
    logic [63:0] wb_inst_id_i;
    wb_sel_t     wb_sel_i;
    logic        rf_wen_i;
    logic [4:0]  rd_addr_i;
    logic [31:0] alu_out_i;
    logic [31:0] mem_rdata_i;
    logic [31:0] csr_rdata_i;
    logic [4:0]  rs1_addr_i;
    logic [4:0]  rs2_addr_i;
    logic [31:0] rs1_data_o;
    logic [31:0] rs2_data_o;
    logic [31:0] wb_data_o;
    logic [31:0] retire_count_o;
    logic        exit_o;

    int          error_count;
    int          check_count;

    logic [31:0] lfsr_state;
    logic [47:0] id_ctr;
    logic [63:0] cur_id;
    logic [4:0]  sweep_addr;
    int          issued_count;
    int          timeout_count;
    int          tests_failed;
    int          test_start;

    wb_top i_dut (.*);

    wb_checker u_checker (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .wb_valid_i     (wb_valid_i),
        .wb_pc_i        (wb_pc_i),
        .wb_inst_id_i   (wb_inst_id_i),
        .wb_sel_i       (wb_sel_i),
        .rf_wen_i       (rf_wen_i),
        .rd_addr_i      (rd_addr_i),
        .alu_out_i      (alu_out_i),
        .mem_rdata_i    (mem_rdata_i),
        .csr_rdata_i    (csr_rdata_i),
        .rs1_addr_i     (rs1_addr_i),
        .rs2_addr_i     (rs2_addr_i),
        .rs1_data_i     (rs1_data_o),
        .rs2_data_i     (rs2_data_o),
        .wb_data_i      (wb_data_o),
        .retire_count_i (retire_count_o),
        .exit_i         (exit_o),
        .error_count_o  (error_count),
        .check_count_o  (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (CYCLE_LIMIT) @(posedge clk);
        $display("simulation did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------

    // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] rand_pc();
        return {30'(lfsr_bits(30)), 2'b00};
    endfunction

    // Top 16 bits stay zero, so an id never equals INST_ID_NONE.
    task automatic fresh_id();
        id_ctr = id_ctr + 48'(lfsr_bits(8)) + 48'd1;
        cur_id = {16'h0000, id_ctr};
        issued_count++;
    endtask

    task automatic drive_inst(input logic valid, input logic [31:0] pc, input wb_sel_t sel,
                              input logic wen, input logic [4:0] rd);
        logic [31:0] alu;
        logic [31:0] mem;
        logic [31:0] csr;
        alu = lfsr_bits(32);
        mem = lfsr_bits(32);
        csr = lfsr_bits(32);
        @(posedge clk);
        wb_valid_i   <= valid;
        wb_pc_i      <= pc;
        wb_inst_id_i <= cur_id;
        wb_sel_i     <= sel;
        rf_wen_i     <= wen;
        rd_addr_i    <= rd;
        alu_out_i    <= alu;
        mem_rdata_i  <= mem;
        csr_rdata_i  <= csr;
        rs1_addr_i   <= sweep_addr;
        rs2_addr_i   <= sweep_addr + 5'd13;  // Second port sweeps out of step.
        sweep_addr = sweep_addr + 5'd1;
    endtask

    task automatic drive_idle();
        drive_inst(1'b0, rand_pc(), WB_ALU, 1'b0, 5'd0);
    endtask

    task automatic wait_retire_count();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (retire_count_o != 32'(issued_count) && n < WAIT_LIMIT);
        if (retire_count_o != 32'(issued_count)) begin
            timeout_count++;
            $display("retire count stayed at %0d and never reached %0d",
                     retire_count_o, issued_count);
        end
    endtask

    task automatic wait_exit();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!exit_o && n < WAIT_LIMIT);
        if (!exit_o) begin
            timeout_count++;
            $display("exit flag did not rise for an instruction at the exit address");
        end
    endtask

    task automatic finish_test(input string name);
        int failures;
        @(posedge clk);
        failures = error_count + timeout_count - test_start;
        if (failures == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d failures", name, failures);
        end
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------

    task automatic reset_state_test();
        test_start = error_count + timeout_count;
        repeat (`WB_REG_COUNT) drive_idle();
        finish_test("reset state");
    endtask

    task automatic result_select_test();
        wb_sel_t sel;
        test_start = error_count + timeout_count;
        for (int i = 0; i < 200; i++) begin
            sel = (i < 8) ? 3'(i) : 3'(lfsr_bits(3));  // Every code at least once.
            fresh_id();
            drive_inst(1'b1, rand_pc(), sel, 1'b0, 5'(lfsr_bits(5)));
        end
        finish_test("result selection");
    endtask

    task automatic register_write_test();
        logic valid;
        logic wen;
        test_start = error_count + timeout_count;
        for (int i = 0; i < 300; i++) begin
            valid = (lfsr_bits(3) != 32'd0);
            wen   = (lfsr_bits(2) != 32'd0);
            if (valid) begin
                fresh_id();
            end
            drive_inst(valid, rand_pc(), 3'(lfsr_bits(3)), wen, 5'(lfsr_bits(5)));
        end
        repeat (`WB_REG_COUNT) drive_idle();
        finish_test("register writes");
    endtask

    task automatic stall_test();
        logic valid;
        int   hold;
        test_start = error_count + timeout_count;
        for (int i = 0; i < 150; i++) begin
            fresh_id();
            hold = 1 + int'(lfsr_bits(2));
            for (int h = 0; h < hold; h++) begin
                valid = (h == 0) || (lfsr_bits(2) != 32'd0);
                drive_inst(valid, rand_pc(), 3'(lfsr_bits(3)), 1'b1, 5'(lfsr_bits(5)));
            end
        end
        repeat (`WB_REG_COUNT) drive_idle();
        wait_retire_count();
        finish_test("stall suppression");
    endtask

    task automatic exit_flag_test();
        logic        valid;
        logic [31:0] pc;
        test_start = error_count + timeout_count;
        for (int i = 0; i < 100; i++) begin
            valid = (lfsr_bits(1) != 32'd0);
            pc    = (lfsr_bits(2) == 32'd0) ? `WB_EXIT_PC : rand_pc();
            if (valid) begin
                fresh_id();
            end
            drive_inst(valid, pc, 3'(lfsr_bits(3)), 1'b0, 5'd0);
        end
        fresh_id();
        drive_inst(1'b1, `WB_EXIT_PC, WB_ALU, 1'b0, 5'd0);
        wait_exit();
        finish_test("exit flag");
    endtask

    initial begin
        lfsr_state    = 32'd90;
        id_ctr        = 48'd0;
        cur_id        = 64'd0;
        sweep_addr    = 5'd0;
        issued_count  = 0;
        timeout_count = 0;
        tests_failed  = 0;
        test_start    = 0;
        arst_n_i     <= 1'b0;
        wb_valid_i   <= 1'b0;
        wb_pc_i      <= 32'd0;
        wb_inst_id_i <= 64'd0;
        wb_sel_i     <= WB_ALU;
        rf_wen_i     <= 1'b0;
        rd_addr_i    <= 5'd0;
        alu_out_i    <= 32'd0;
        mem_rdata_i  <= 32'd0;
        csr_rdata_i  <= 32'd0;
        rs1_addr_i   <= 5'd0;
        rs2_addr_i   <= 5'd0;
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;

        reset_state_test();
        result_select_test();
        register_write_test();
        stall_test();
        exit_flag_test();

        $display("tests run: 5, tests failed: %0d, checks: %0d, mismatches: %0d, timeouts: %0d",
                 tests_failed, check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+common
common/wb_pkg.sv
writeback/wb_stage.sv
writeback/reg_file.sv
verilog/wb_top.sv
test/wb_properties.sv
test/wb_checker.sv
test/wb_tb.sv

// ==== Makefile ====
all: run

build:
	verilator --binary --timing --assert -f all.f --top-module wb_tb

run: build
	./obj_dir/Vwb_tb > sim.log 2>&1; cat sim.log
	grep -qx "NO ERRORS" sim.log

lint:
	verilator --lint-only --timing --assert -f all.f --top-module wb_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
